// ==== logic/video_pkg.sv ====
package video_pkg;

	////////////////////
	// shared types
	////////////////////

	// screen coordinate, also used for bar positions and openings
	typedef logic [9:0] coord_t;

	// score glyph mask, cells in row order
	// rows 0, 2, 4 hold three cells, rows 1 and 3 only the outer two
	typedef logic [12:0] glyph_t;

	// packed 12-bit colour
	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb_t;

	////////////////////
	// 640x480 timing
	////////////////////

	// horizontal, in pixels
	localparam coord_t H_DISPLAY       = 10'd640;
	localparam coord_t H_R_BORDER      = 10'd16;
	localparam coord_t H_RETRACE       = 10'd96;
	localparam coord_t H_L_BORDER      = 10'd48;
	localparam coord_t H_MAX           = H_DISPLAY + H_L_BORDER + H_R_BORDER + H_RETRACE - 10'd1;
	localparam coord_t H_RETRACE_START = H_DISPLAY + H_R_BORDER;
	localparam coord_t H_RETRACE_END   = H_RETRACE_START + H_RETRACE - 10'd1;

	// vertical, in lines
	localparam coord_t V_DISPLAY       = 10'd480;
	localparam coord_t V_B_BORDER      = 10'd33;
	localparam coord_t V_RETRACE       = 10'd2;
	localparam coord_t V_T_BORDER      = 10'd10;
	localparam coord_t V_MAX           = V_DISPLAY + V_T_BORDER + V_B_BORDER + V_RETRACE - 10'd1;
	localparam coord_t V_RETRACE_START = V_DISPLAY + V_B_BORDER;
	localparam coord_t V_RETRACE_END   = V_RETRACE_START + V_RETRACE - 10'd1;

	// system clocks per pixel (100 MHz in, 25 MHz pixel)
	localparam int unsigned PIXEL_DIV = 4;

	////////////////////
	// game layout
	////////////////////

	localparam int unsigned NUM_COLUMNS = 8;
	localparam coord_t COLUMN_WIDTH = 10'd80;
	// player square is twice this on a side
	localparam coord_t PLAYER_HALF = 10'd20;
	// glyph cell edge, glyph box is 3x5 cells
	localparam coord_t CELL_SIZE = 10'd4;
	localparam coord_t GLYPH_Y = 10'd10;

	// colours
	localparam rgb_t COLOR_BLACK   = 12'h000;
	localparam rgb_t COLOR_YELLOW  = 12'hFF0;
	localparam rgb_t COLOR_WHITE   = 12'hFFF;
	localparam rgb_t COLOR_MAGENTA = 12'hF0F;
	localparam rgb_t COLOR_BLUE    = 12'h00F;

endpackage

// ==== logic/vga_timing.sv ====
`timescale 1ns/1ps

module vga_timing
(
	input  logic               clk,
	input  logic               reset,
	output video_pkg::coord_t  x,
	output video_pkg::coord_t  y,
	output logic               hsync,
	output logic               vsync
);

	////////////////////
	// pixel tick
	////////////////////

	localparam int unsigned DIV_W = $clog2(video_pkg::PIXEL_DIV);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(video_pkg::PIXEL_DIV - 1);

	logic [DIV_W-1:0] div_cnt;
	logic pixel_tick;
	logic x_last;
	logic y_last;
	logic hsync_next;
	logic vsync_next;

	// free running divider
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			div_cnt <= '0;
		else if (div_cnt == DIV_LAST)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	// tick on the first clock out of reset, then once per PIXEL_DIV
	assign pixel_tick = (div_cnt == '0);

	////////////////////
	// position counters
	////////////////////

	assign x_last = (x == video_pkg::H_MAX);
	assign y_last = (y == video_pkg::V_MAX);

	// x moves every tick
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			x <= '0;
		else if (pixel_tick)
		begin
			if (x_last)
				x <= '0;
			else
				x <= x + 10'd1;
		end
	end

	// y only at end of line
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			y <= '0;
		else if (pixel_tick && x_last)
		begin
			if (y_last)
				y <= '0;
			else
				y <= y + 10'd1;
		end
	end

	////////////////////
	// sync outputs
	////////////////////

	// high while inside the retrace window
	assign hsync_next = (x >= video_pkg::H_RETRACE_START) && (x <= video_pkg::H_RETRACE_END);
	assign vsync_next = (y >= video_pkg::V_RETRACE_START) && (y <= video_pkg::V_RETRACE_END);

	// registered every clock, so one clock behind the counters
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			hsync <= 1'b0;
			vsync <= 1'b0;
		end
		else
		begin
			hsync <= hsync_next;
			vsync <= vsync_next;
		end
	end

endmodule

// ==== logic/pipe_renderer.sv ====
`timescale 1ns/1ps

module pipe_renderer
(
	input  video_pkg::coord_t                              x,
	input  video_pkg::coord_t                              y,
	input  video_pkg::coord_t [video_pkg::NUM_COLUMNS-1:0] bar_pos,
	input  video_pkg::coord_t [video_pkg::NUM_COLUMNS-1:0] bar_open,
	output logic                                           gap_hit
);

	// index width for one of the columns
	localparam int unsigned SEL_W = $clog2(video_pkg::NUM_COLUMNS);

	// last inner column, the outer two never show a gap
	localparam int unsigned LAST_INNER = video_pkg::NUM_COLUMNS - 2;

	////////////////////
	// column lookup
	////////////////////

	video_pkg::coord_t col_full;
	logic [3:0] col;
	logic [SEL_W-1:0] sel;
	logic inner;

	// x up to H_MAX, so col runs 0..9 across the whole line
	assign col_full = x / video_pkg::COLUMN_WIDTH;
	assign col = col_full[3:0];

	// only meaningful when inner is set
	assign sel = col[SEL_W-1:0];

	// inner columns 1 to 6
	assign inner = (col >= 4'd1) && (col <= 4'(LAST_INNER));

	////////////////////
	// gap window
	////////////////////

	video_pkg::coord_t gap_top;
	video_pkg::coord_t gap_len;
	logic [10:0] gap_end;
	logic below_top;
	logic above_end;

	assign gap_top = bar_pos[sel];
	assign gap_len = bar_open[sel];

	// one extra bit so a gap low on the screen does not wrap
	assign gap_end = {1'b0, gap_top} + {1'b0, gap_len};

	// both bounds exclusive
	assign below_top = (y > gap_top);
	assign above_end = ({1'b0, y} < gap_end);

	assign gap_hit = inner && below_top && above_end;

endmodule

// ==== logic/score_glyph.sv ====
`timescale 1ns/1ps

module score_glyph
#(
	parameter video_pkg::coord_t X_ORIGIN = 10'd10,
	parameter logic              MIRROR   = 1'b0
)
(
	input  video_pkg::coord_t  x,
	input  video_pkg::coord_t  y,
	input  video_pkg::glyph_t  glyph,
	output logic               glyph_hit
);

	// glyph box, 3 cells wide and 5 high
	localparam video_pkg::coord_t BOX_W = 10'd3 * video_pkg::CELL_SIZE;
	localparam video_pkg::coord_t BOX_H = 10'd5 * video_pkg::CELL_SIZE;

	////////////////////
	// cell position
	////////////////////

	logic in_box;
	video_pkg::coord_t dx;
	video_pkg::coord_t dy;
	video_pkg::coord_t col_full;
	video_pkg::coord_t row_full;
	logic [1:0] cell_col;
	logic [2:0] cell_row;
	logic [1:0] col_eff;

	assign in_box = (x >= X_ORIGIN) && (x < X_ORIGIN + BOX_W)
		&& (y >= video_pkg::GLYPH_Y) && (y < video_pkg::GLYPH_Y + BOX_H);

	// offsets inside the box
	assign dx = x - X_ORIGIN;
	assign dy = y - video_pkg::GLYPH_Y;

	assign col_full = dx / video_pkg::CELL_SIZE;
	assign row_full = dy / video_pkg::CELL_SIZE;
	assign cell_col = col_full[1:0];
	assign cell_row = row_full[2:0];

	// mirrored digit reads each row right to left
	assign col_eff = MIRROR ? (2'd2 - cell_col) : cell_col;

	////////////////////
	// mask bit select
	////////////////////

	logic has_cell;
	logic [3:0] bit_idx;

	always_comb
	begin
		has_cell = 1'b1;
		bit_idx  = 4'd0;
		case (cell_row)
			// full rows start at bits 0, 5 and 10
			3'd0: bit_idx = {2'b00, col_eff};
			3'd2: bit_idx = 4'd5 + {2'b00, col_eff};
			3'd4: bit_idx = 4'd10 + {2'b00, col_eff};
			3'd1, 3'd3:
			begin
				// outer cells only, centre is never lit
				has_cell = (col_eff != 2'd1);
				bit_idx  = ((cell_row == 3'd1) ? 4'd3 : 4'd8) + {3'b000, col_eff[1]};
			end
			default: has_cell = 1'b0;
		endcase
	end

	assign glyph_hit = in_box && has_cell && glyph[bit_idx];

endmodule

// ==== logic/pixel_compositor.sv ====
`timescale 1ns/1ps

module pixel_compositor
(
	input  video_pkg::coord_t  x,
	input  video_pkg::coord_t  y,
	input  video_pkg::coord_t  player_h,
	input  video_pkg::coord_t  player_v,
	input  logic               gap_hit,
	input  logic               glyph_hit,
	output logic [3:0]         red,
	output logic [3:0]         green,
	output logic [3:0]         blue
);

	////////////////////
	// player square
	////////////////////

	video_pkg::coord_t box_left;
	video_pkg::coord_t box_right;
	video_pkg::coord_t box_top;
	video_pkg::coord_t box_bottom;
	logic in_player;

	// centred on the player, right and bottom edges exclusive
	assign box_left   = player_h - video_pkg::PLAYER_HALF;
	assign box_right  = player_h + video_pkg::PLAYER_HALF;
	assign box_top    = player_v - video_pkg::PLAYER_HALF;
	assign box_bottom = player_v + video_pkg::PLAYER_HALF;

	assign in_player = (x >= box_left) && (x < box_right)
		&& (y >= box_top) && (y < box_bottom);

	////////////////////
	// layer priority
	////////////////////

	video_pkg::rgb_t pixel;

	always_comb
	begin
		// rows below the picture
		if (y >= video_pkg::V_DISPLAY)
			pixel = video_pkg::COLOR_BLUE;
		// borders and retrace on a visible row
		else if (x >= video_pkg::H_DISPLAY)
			pixel = video_pkg::COLOR_BLACK;
		// score sits over everything
		else if (glyph_hit)
			pixel = video_pkg::COLOR_MAGENTA;
		else if (in_player)
			pixel = video_pkg::COLOR_WHITE;
		// pipe gap
		else if (gap_hit)
			pixel = video_pkg::COLOR_YELLOW;
		else
			pixel = video_pkg::COLOR_BLACK;
	end

	// split to the three DAC channels
	assign red   = pixel.r;
	assign green = pixel.g;
	assign blue  = pixel.b;

endmodule

// ==== logic/game_display_top.sv ====
`timescale 1ns/1ps

module game_display_top
#(
	parameter video_pkg::coord_t LEFT_X  = 10'd10,
	parameter video_pkg::coord_t RIGHT_X = 10'd30
)
(
	input  logic                                           clk,
	input  logic                                           reset,
	input  video_pkg::coord_t [video_pkg::NUM_COLUMNS-1:0] bar_pos,
	input  video_pkg::coord_t [video_pkg::NUM_COLUMNS-1:0] bar_open,
	input  video_pkg::coord_t                              player_h,
	input  video_pkg::coord_t                              player_v,
	input  video_pkg::glyph_t                              digit_left,
	input  video_pkg::glyph_t                              digit_right,
	output logic                                           hsync,
	output logic                                           vsync,
	output logic [3:0]                                     red,
	output logic [3:0]                                     green,
	output logic [3:0]                                     blue
);

	video_pkg::coord_t x;
	video_pkg::coord_t y;
	logic gap_hit;
	logic left_hit;
	logic right_hit;

	////////////////////
	// timing
	////////////////////

	vga_timing u_timing (.clk(clk), .reset(reset), .x(x), .y(y), .hsync(hsync), .vsync(vsync));

	////////////////////
	// renderers
	////////////////////

	pipe_renderer u_pipes (.x(x), .y(y), .bar_pos(bar_pos), .bar_open(bar_open), .gap_hit(gap_hit));

	// left digit is stored mirrored
	score_glyph #(.X_ORIGIN(LEFT_X), .MIRROR(1'b1)) u_glyph_left
	(
		.x(x),
		.y(y),
		.glyph(digit_left),
		.glyph_hit(left_hit)
	);

	score_glyph #(.X_ORIGIN(RIGHT_X), .MIRROR(1'b0)) u_glyph_right
	(
		.x(x),
		.y(y),
		.glyph(digit_right),
		.glyph_hit(right_hit)
	);

	////////////////////
	// output colour
	////////////////////

	// boxes do not overlap, so one hit line is enough
	pixel_compositor u_compositor
	(
		.x(x),
		.y(y),
		.player_h(player_h),
		.player_v(player_v),
		.gap_hit(gap_hit),
		.glyph_hit(left_hit | right_hit),
		.red(red),
		.green(green),
		.blue(blue)
	);

endmodule

// ==== testbench/display_model.svh ====
`ifndef DISPLAY_MODEL_SVH
`define DISPLAY_MODEL_SVH

//////////////////////
// position model
//////////////////////

// pixels since reset release, the first tick lands in the first clock
function automatic int pixel_of_cycle(input int cycle);
	return (cycle + video_pkg::PIXEL_DIV - 1) / video_pkg::PIXEL_DIV;
endfunction

function automatic int x_of_cycle(input int cycle);
	return pixel_of_cycle(cycle) % (int'(video_pkg::H_MAX) + 1);
endfunction

function automatic int y_of_cycle(input int cycle);
	return (pixel_of_cycle(cycle) / (int'(video_pkg::H_MAX) + 1)) % (int'(video_pkg::V_MAX) + 1);
endfunction

// retrace windows, counted from their start over their length
function automatic bit in_hretrace(input int px);
	return px >= int'(video_pkg::H_RETRACE_START)
		&& px < int'(video_pkg::H_RETRACE_START) + int'(video_pkg::H_RETRACE);
endfunction

function automatic bit in_vretrace(input int py);
	return py >= int'(video_pkg::V_RETRACE_START)
		&& py < int'(video_pkg::V_RETRACE_START) + int'(video_pkg::V_RETRACE);
endfunction

//////////////////////
// picture model
//////////////////////

function automatic bit in_player_box(input int px, input int py, input int ph, input int pv);
	return px >= ph - int'(video_pkg::PLAYER_HALF) && px < ph + int'(video_pkg::PLAYER_HALF)
		&& py >= pv - int'(video_pkg::PLAYER_HALF) && py < pv + int'(video_pkg::PLAYER_HALF);
endfunction

// one glyph, cells counted in row order
function automatic bit glyph_cell_lit(input int px, input int py, input int x0,
	input video_pkg::glyph_t mask, input bit mirror);
	int size;
	int col;
	int row;
	int idx;
	size = int'(video_pkg::CELL_SIZE);
	if (px < x0 || px >= x0 + 3 * size)
		return 1'b0;
	if (py < int'(video_pkg::GLYPH_Y) || py >= int'(video_pkg::GLYPH_Y) + 5 * size)
		return 1'b0;
	col = (px - x0) / size;
	row = (py - int'(video_pkg::GLYPH_Y)) / size;
	if (mirror)
		col = 2 - col;
	// each pair of rows holds five cells, three then two
	idx = (row / 2) * 5 + (row % 2) * 3;
	if (row % 2 == 1)
	begin
		// narrow rows have no centre cell
		if (col == 1)
			return 1'b0;
		idx = idx + col / 2;
	end
	else
		idx = idx + col;
	return mask[idx];
endfunction

function automatic video_pkg::rgb_t expected_color(input int px, input int py,
	input video_pkg::coord_t [video_pkg::NUM_COLUMNS-1:0] pos,
	input video_pkg::coord_t [video_pkg::NUM_COLUMNS-1:0] opening,
	input int ph, input int pv, input video_pkg::glyph_t mask_left,
	input video_pkg::glyph_t mask_right, input int left_x, input int right_x);
	int col;
	bit gap;
	if (py >= int'(video_pkg::V_DISPLAY))
		return video_pkg::COLOR_BLUE;
	if (px >= int'(video_pkg::H_DISPLAY))
		return video_pkg::COLOR_BLACK;
	if (glyph_cell_lit(px, py, left_x, mask_left, 1'b1)
		|| glyph_cell_lit(px, py, right_x, mask_right, 1'b0))
		return video_pkg::COLOR_MAGENTA;
	if (in_player_box(px, py, ph, pv))
		return video_pkg::COLOR_WHITE;
	// outer columns never open
	col = px / int'(video_pkg::COLUMN_WIDTH);
	gap = col >= 1 && col <= int'(video_pkg::NUM_COLUMNS) - 2 && py > int'(pos[col])
		&& py < int'(pos[col]) + int'(opening[col]);
	return gap ? video_pkg::COLOR_YELLOW : video_pkg::COLOR_BLACK;
endfunction

`endif

// ==== testbench/tb_game_display.sv ====
`timescale 1ns/1ps

module tb_game_display;

	localparam int CLK_PERIOD = 20;
	localparam video_pkg::coord_t LEFT_X = 10'd10;
	localparam video_pkg::coord_t RIGHT_X = 10'd30;
	localparam int LINE_CLOCKS = (int'(video_pkg::H_MAX) + 1) * video_pkg::PIXEL_DIV;
	localparam int FRAME_CLOCKS = LINE_CLOCKS * (int'(video_pkg::V_MAX) + 1);
	localparam int FRAME_PIXELS = FRAME_CLOCKS / video_pkg::PIXEL_DIV;
	// x reaches n after (n-1)*4+1 clocks, sync follows one clock later
	localparam int FIRST_HRISE = (int'(video_pkg::H_RETRACE_START) - 1) * video_pkg::PIXEL_DIV + 2;
	localparam int WATCHDOG_CLOCKS = FRAME_CLOCKS * 22 / 10;

	logic clk;
	logic reset;
	video_pkg::coord_t [video_pkg::NUM_COLUMNS-1:0] bar_pos;
	video_pkg::coord_t [video_pkg::NUM_COLUMNS-1:0] bar_open;
	video_pkg::coord_t player_h;
	video_pkg::coord_t player_v;
	video_pkg::glyph_t digit_left;
	video_pkg::glyph_t digit_right;
	logic hsync;
	logic vsync;
	logic [3:0] red;
	logic [3:0] green;
	logic [3:0] blue;

	int cycle;
	int checks [1:6];
	int errors [1:6];
	int h_rise = -1;
	int v_rise = -1;
	int v_periods = 0;
	logic h_prev = 1'b0;
	logic v_prev = 1'b0;

	`include "display_model.svh"

	game_display_top #(.LEFT_X(LEFT_X), .RIGHT_X(RIGHT_X)) DUT
	(
		.clk(clk), .reset(reset), .bar_pos(bar_pos), .bar_open(bar_open),
		.player_h(player_h), .player_v(player_v), .digit_left(digit_left),
		.digit_right(digit_right), .hsync(hsync), .vsync(vsync),
		.red(red), .green(green), .blue(blue)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////
	// reporting
	////////////////////

	function automatic string test_name(input int t);
		case (t)
			1: return "hsync timing";
			2: return "vsync timing";
			3: return "columns and gaps";
			4: return "player square";
			5: return "score glyphs";
			default: return "blanking";
		endcase
	endfunction

	task automatic log_mismatch(input int t, input string sig, input string exp_s, input string got_s);
		errors[t]++;
		$display("mismatch at %0t: %s expected %s got %s", $time, sig, exp_s, got_s);
	endtask

	task automatic report_test(input int t);
		$display("test %0d %s: %0d checks, %0d errors, %s", t, test_name(t), checks[t],
			errors[t], (errors[t] == 0) ? "ok" : "failed");
	endtask

	////////////////////
	// comparing process
	////////////////////

	task automatic check_current();
		int px;
		int py;
		int t;
		video_pkg::rgb_t exp_rgb;
		video_pkg::rgb_t got_rgb;
		logic exp_h;
		logic exp_v;
		px = x_of_cycle(cycle);
		py = y_of_cycle(cycle);
		exp_rgb = expected_color(px, py, bar_pos, bar_open, player_h, player_v,
			digit_left, digit_right, LEFT_X, RIGHT_X);
		got_rgb = {red, green, blue};
		// sort the pixel into the test it belongs to
		if (py >= int'(video_pkg::V_DISPLAY) || px >= int'(video_pkg::H_DISPLAY))
			t = 6;
		else if (pixel_of_cycle(cycle) >= FRAME_PIXELS && px >= LEFT_X && px < RIGHT_X + 12
			&& py >= video_pkg::GLYPH_Y && py < video_pkg::GLYPH_Y + 20)
			t = 5;
		else if (in_player_box(px, py, player_h, player_v))
			t = 4;
		else
			t = 3;
		checks[t]++;
		if (got_rgb !== exp_rgb)
			log_mismatch(t, $sformatf("{red,green,blue} at (%0d,%0d)", px, py),
				$sformatf("%h", exp_rgb), $sformatf("%h", got_rgb));
		// registered sync trails the counters by one clock
		exp_h = (cycle > 0) && in_hretrace(x_of_cycle(cycle - 1));
		exp_v = (cycle > 0) && in_vretrace(y_of_cycle(cycle - 1));
		checks[1]++;
		if (hsync !== exp_h)
			log_mismatch(1, "hsync", $sformatf("%b", exp_h), $sformatf("%b", hsync));
		checks[2]++;
		if (vsync !== exp_v)
			log_mismatch(2, "vsync", $sformatf("%b", exp_v), $sformatf("%b", vsync));
		// edge spacing
		if (hsync === 1'b1 && h_prev === 1'b0)
		begin
			checks[1]++;
			if (h_rise < 0 && cycle != FIRST_HRISE)
				log_mismatch(1, "hsync first rise clock", $sformatf("%0d", FIRST_HRISE),
					$sformatf("%0d", cycle));
			if (h_rise >= 0 && cycle - h_rise != LINE_CLOCKS)
				log_mismatch(1, "hsync period", $sformatf("%0d", LINE_CLOCKS),
					$sformatf("%0d", cycle - h_rise));
			h_rise = cycle;
		end
		if (hsync === 1'b0 && h_prev === 1'b1)
		begin
			checks[1]++;
			if (cycle - h_rise != int'(video_pkg::H_RETRACE) * video_pkg::PIXEL_DIV)
				log_mismatch(1, "hsync width", "384", $sformatf("%0d", cycle - h_rise));
		end
		if (vsync === 1'b1 && v_prev === 1'b0)
		begin
			checks[2]++;
			if (v_rise >= 0 && cycle - v_rise != FRAME_CLOCKS)
				log_mismatch(2, "vsync period", $sformatf("%0d", FRAME_CLOCKS),
					$sformatf("%0d", cycle - v_rise));
			if (v_rise >= 0)
				v_periods++;
			v_rise = cycle;
		end
		if (vsync === 1'b0 && v_prev === 1'b1)
		begin
			checks[2]++;
			if (cycle - v_rise != int'(video_pkg::V_RETRACE) * LINE_CLOCKS)
				log_mismatch(2, "vsync width", "6400", $sformatf("%0d", cycle - v_rise));
		end
		h_prev = hsync;
		v_prev = vsync;
	endtask

	// sample mid high phase, away from both clock edges
	initial
	begin
		cycle = 0;
		@(negedge reset);
		#5;
		check_current();
		forever
		begin
			@(posedge clk);
			cycle++;
			#5;
			check_current();
		end
	end

	////////////////////
	// stimulus
	////////////////////

	task automatic randomize_columns();
		for (int i = 0; i < video_pkg::NUM_COLUMNS; i++)
		begin
			bar_pos[i] = 10'($urandom % 480);
			bar_open[i] = 10'(20 + $urandom % 160);
		end
	endtask

	initial
	begin : stimulus
		int seed;
		int total_checks;
		int total_errors;
		seed = $urandom(49);
		for (int t = 1; t <= 6; t++)
		begin
			checks[t] = 0;
			errors[t] = 0;
		end
		reset = 1'b1;
		randomize_columns();
		player_h = 10'(20 + $urandom % 581);
		// centre kept on a visible row so the square shows in frame 1
		player_v = 10'(20 + $urandom % 440);
		digit_left = '0;
		digit_right = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		// frame 2 inputs go in during the blue rows closing frame 1
		wait (cycle >= FRAME_CLOCKS - LINE_CLOCKS);
		@(negedge clk);
		report_test(3);
		report_test(4);
		randomize_columns();
		// player square over both glyph boxes
		player_h = 10'd30;
		player_v = 10'd25;
		digit_left = video_pkg::glyph_t'($urandom);
		digit_right = video_pkg::glyph_t'($urandom);
		wait (cycle >= 2 * FRAME_CLOCKS);
		@(negedge clk);
		if (v_periods == 0)
		begin
			errors[2]++;
			$display("vsync did not rise twice, so its period was never measured");
		end
		report_test(1);
		report_test(2);
		report_test(5);
		report_test(6);
		total_checks = 0;
		total_errors = 0;
		for (int t = 1; t <= 6; t++)
		begin
			total_checks += checks[t];
			total_errors += errors[t];
		end
		$display("tests: 6, checks: %0d, errors: %0d", total_checks, total_errors);
		if (total_errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// two frames of tests plus a margin
	initial
	begin
		#(CLK_PERIOD * WATCHDOG_CLOCKS);
		$display("timeout: the run did not finish within %0d clocks", WATCHDOG_CLOCKS);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== sources.f ====
logic/video_pkg.sv
logic/vga_timing.sv
logic/pipe_renderer.sv
logic/score_glyph.sv
logic/pixel_compositor.sv
logic/game_display_top.sv
+incdir+testbench
testbench/tb_game_display.sv

// ==== Bender.yml ====
package:
  name: game_display

sources:
  - logic/video_pkg.sv
  - logic/vga_timing.sv
  - logic/pipe_renderer.sv
  - logic/score_glyph.sv
  - logic/pixel_compositor.sv
  - logic/game_display_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_game_display.sv
